//--- Makefile
VERILATOR = verilator
VFLAGS = --binary --assert -Wno-fatal
TOP = tb_core
FILELIST = sources.f
OBJ_DIR = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf $(OBJ_DIR)

//--- design/alu.sv
module alu (
	input  logic [pipe_pkg::ALU_OP_BITS-1:0] op,
	input  logic [4:0]                       dest,
	input  logic [31:0]                      opnd1,
	input  logic [31:0]                      opnd2,
	output logic [31:0]                      result
);
	import pipe_pkg::*;

	logic [31:0] raw;

	always_comb
	begin
		case (op)
			ALU_ADD: raw = opnd1 + opnd2;
			ALU_SUB: raw = opnd1 - opnd2;
			ALU_AND: raw = opnd1 & opnd2;
			ALU_OR:  raw = opnd1 | opnd2;
			ALU_XOR: raw = opnd1 ^ opnd2;
			ALU_SLT: raw = {31'd0, $signed(opnd1) < $signed(opnd2)};
			ALU_LUI: raw = {opnd2[15:0], 16'h0};
			default: raw = 32'd0;
		endcase
	end

	// register 0 result is zero everywhere it is seen
	assign result = (dest == 5'd0) ? 32'd0 : raw;

endmodule

//--- design/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// instruction queue entries, also the sender's credits after reset
`define CORE_QUEUE_DEPTH 8

// result FIFO entries on the output side
`define CORE_RETIRE_DEPTH 8

// credits the consumer grants after reset
`define CORE_RETIRE_CREDITS 4

// register index width
`define CORE_REG_BITS 5

`endif

//--- design/dual_issue_core.sv
`include "core_params.svh"

module dual_issue_core (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      inst_valid,
	input  logic [31:0]               inst_word,
	output logic                      inst_credit,
	output logic                      retire_valid,
	output logic [`CORE_REG_BITS-1:0] retire_reg,
	output logic [31:0]               retire_data,
	input  logic                      retire_credit
);
	import isa_pkg::*;
	import pipe_pkg::*;

	logic                      head_valid_a;
	logic                      head_valid_b;
	inst_word_t                head_word_a;
	inst_word_t                head_word_b;
	logic                      pop_one;
	logic                      pop_two;
	logic [`CORE_REG_BITS-1:0] rd_addr1;
	logic [`CORE_REG_BITS-1:0] rd_addr2;
	logic [`CORE_REG_BITS-1:0] rd_addr3;
	logic [`CORE_REG_BITS-1:0] rd_addr4;
	logic [31:0]               rd_data1;
	logic [31:0]               rd_data2;
	logic [31:0]               rd_data3;
	logic [31:0]               rd_data4;
	logic [3:0]                room;
	logic                      ex_valid_a;
	logic                      ex_valid_b;
	logic [ALU_OP_BITS-1:0]    ex_op_a;
	logic [ALU_OP_BITS-1:0]    ex_op_b;
	logic [`CORE_REG_BITS-1:0] ex_dest_a;
	logic [`CORE_REG_BITS-1:0] ex_dest_b;
	logic [31:0]               ex_opnd1_a;
	logic [31:0]               ex_opnd2_a;
	logic [31:0]               ex_opnd1_b;
	logic [31:0]               ex_opnd2_b;
	logic [31:0]               res_a;
	logic [31:0]               res_b;

	inst_queue u_queue (
		.clk,
		.rst_n,
		.inst_valid,
		.inst_word,
		.pop_one,
		.pop_two,
		.head_valid_a,
		.head_word_a,
		.head_valid_b,
		.head_word_b,
		.inst_credit
	);

	issue_ctrl u_issue (
		.clk,
		.rst_n,
		.head_valid_a,
		.head_word_a,
		.head_valid_b,
		.head_word_b,
		.pop_one,
		.pop_two,
		.rd_addr1,
		.rd_addr2,
		.rd_addr3,
		.rd_addr4,
		.rd_data1,
		.rd_data2,
		.rd_data3,
		.rd_data4,
		.res_a,
		.res_b,
		.room,
		.ex_valid_a,
		.ex_op_a,
		.ex_dest_a,
		.ex_opnd1_a,
		.ex_opnd2_a,
		.ex_valid_b,
		.ex_op_b,
		.ex_dest_b,
		.ex_opnd1_b,
		.ex_opnd2_b
	);

	// slot a reads ports 1-2, slot b ports 3-4
	reg_file u_regs (
		.clk,
		.rst_n,
		.raddr1(rd_addr1),
		.raddr2(rd_addr2),
		.raddr3(rd_addr3),
		.raddr4(rd_addr4),
		.rdata1(rd_data1),
		.rdata2(rd_data2),
		.rdata3(rd_data3),
		.rdata4(rd_data4),
		.we_a(ex_valid_a),
		.waddr_a(ex_dest_a),
		.wdata_a(res_a),
		.we_b(ex_valid_b),
		.waddr_b(ex_dest_b),
		.wdata_b(res_b)
	);

	alu alu_a (
		.op(ex_op_a),
		.dest(ex_dest_a),
		.opnd1(ex_opnd1_a),
		.opnd2(ex_opnd2_a),
		.result(res_a)
	);

	alu alu_b (
		.op(ex_op_b),
		.dest(ex_dest_b),
		.opnd1(ex_opnd1_b),
		.opnd2(ex_opnd2_b),
		.result(res_b)
	);

	retire_port u_retire (
		.clk,
		.rst_n,
		.push_a(ex_valid_a),
		.reg_a(ex_dest_a),
		.data_a(res_a),
		.push_b(ex_valid_b),
		.reg_b(ex_dest_b),
		.data_b(res_b),
		.room,
		.retire_credit,
		.retire_valid,
		.retire_reg,
		.retire_data
	);

endmodule

//--- design/inst_queue.sv
`include "core_params.svh"

module inst_queue (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                inst_valid,
	input  logic [31:0]         inst_word,
	input  logic                pop_one,
	input  logic                pop_two,
	output logic                head_valid_a,
	output isa_pkg::inst_word_t head_word_a,
	output logic                head_valid_b,
	output isa_pkg::inst_word_t head_word_b,
	output logic                inst_credit
);
	import isa_pkg::*;

	localparam int DEPTH = `CORE_QUEUE_DEPTH;
	localparam int PTR = $clog2(DEPTH);
	localparam int CNT = PTR + 1;

	inst_word_t     mem [DEPTH];
	logic [PTR-1:0] wr_ptr;
	logic [PTR-1:0] rd_ptr;
	logic [CNT-1:0] count;
	logic [CNT-1:0] credit_pend;
	logic [1:0]     n_pop;

	assign n_pop = pop_two ? 2'd2 : {1'b0, pop_one};

	// two oldest entries
	assign head_valid_a = count != '0;
	assign head_valid_b = count[CNT-1:1] != '0;
	assign head_word_a = mem[rd_ptr];
	assign head_word_b = mem[rd_ptr + 1'b1];

	// first credit of a pop goes out at once, the rest wait in credit_pend
	assign inst_credit = (n_pop != 2'd0) || (credit_pend != '0);

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit_pend <= '0;
		end
		else
		begin
			if (inst_valid)
				wr_ptr <= wr_ptr + 1'b1;
			rd_ptr <= rd_ptr + PTR'(n_pop);
			count <= count + CNT'(inst_valid) - CNT'(n_pop);
			credit_pend <= credit_pend + CNT'(n_pop) - CNT'(inst_credit);
		end
	end

	always_ff @(posedge clk)
	begin
		if (inst_valid)
			mem[wr_ptr] <= inst_word;
	end

endmodule

//--- design/isa_pkg.sv
package isa_pkg;

	// one instruction word, viewed as R-type or I-type
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm;
		} i;
	} inst_word_t;

	// primary opcodes
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] OP_ADDIU   = 6'h09;
	localparam logic [5:0] OP_ANDI    = 6'h0c;
	localparam logic [5:0] OP_ORI     = 6'h0d;
	localparam logic [5:0] OP_XORI    = 6'h0e;
	localparam logic [5:0] OP_LUI     = 6'h0f;

	// funct codes under OP_SPECIAL
	localparam logic [5:0] FN_ADDU = 6'h21;
	localparam logic [5:0] FN_SUBU = 6'h23;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_XOR  = 6'h26;
	localparam logic [5:0] FN_SLT  = 6'h2a;

endpackage

//--- design/issue_ctrl.sv
`include "core_params.svh"

module issue_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              head_valid_a,
	input  isa_pkg::inst_word_t               head_word_a,
	input  logic                              head_valid_b,
	input  isa_pkg::inst_word_t               head_word_b,
	output logic                              pop_one,
	output logic                              pop_two,
	output logic [`CORE_REG_BITS-1:0]         rd_addr1,
	output logic [`CORE_REG_BITS-1:0]         rd_addr2,
	output logic [`CORE_REG_BITS-1:0]         rd_addr3,
	output logic [`CORE_REG_BITS-1:0]         rd_addr4,
	input  logic [31:0]                       rd_data1,
	input  logic [31:0]                       rd_data2,
	input  logic [31:0]                       rd_data3,
	input  logic [31:0]                       rd_data4,
	input  logic [31:0]                       res_a,
	input  logic [31:0]                       res_b,
	input  logic [3:0]                        room,
	output logic                              ex_valid_a,
	output logic [pipe_pkg::ALU_OP_BITS-1:0]  ex_op_a,
	output logic [`CORE_REG_BITS-1:0]         ex_dest_a,
	output logic [31:0]                       ex_opnd1_a,
	output logic [31:0]                       ex_opnd2_a,
	output logic                              ex_valid_b,
	output logic [pipe_pkg::ALU_OP_BITS-1:0]  ex_op_b,
	output logic [`CORE_REG_BITS-1:0]         ex_dest_b,
	output logic [31:0]                       ex_opnd1_b,
	output logic [31:0]                       ex_opnd2_b
);
	import isa_pkg::*;
	import pipe_pkg::*;

	// up to two in execute plus two issuing
	localparam int NEED_BITS = $clog2(2 * ISSUE_SLOTS + 1);

	logic [ALU_OP_BITS-1:0]    op_a;
	logic [ALU_OP_BITS-1:0]    op_b;
	logic [`CORE_REG_BITS-1:0] dest_a;
	logic [`CORE_REG_BITS-1:0] dest_b;
	logic                      use_imm_a;
	logic                      use_imm_b;
	logic [31:0]               imm_a;
	logic [31:0]               imm_b;
	logic [NEED_BITS-1:0]      n_ex;
	logic                      dep_b;
	logic                      issue_one;
	logic                      issue_two;

	// unsupported words fall through as a nop to register 0
	function automatic void decode(
		input  inst_word_t                w,
		output logic [ALU_OP_BITS-1:0]    op,
		output logic [`CORE_REG_BITS-1:0] src1,
		output logic [`CORE_REG_BITS-1:0] src2,
		output logic [`CORE_REG_BITS-1:0] dest,
		output logic                      use_imm,
		output logic [31:0]               imm
	);
		op = ALU_NOP;
		src1 = '0;
		src2 = '0;
		dest = '0;
		use_imm = 1'b0;
		imm = '0;
		case (w.r.op)
			OP_SPECIAL:
			begin
				src1 = w.r.rs;
				src2 = w.r.rt;
				dest = w.r.rd;
				case (w.r.funct)
					FN_ADDU: op = ALU_ADD;
					FN_SUBU: op = ALU_SUB;
					FN_AND:  op = ALU_AND;
					FN_OR:   op = ALU_OR;
					FN_XOR:  op = ALU_XOR;
					FN_SLT:  op = ALU_SLT;
					default:
					begin
						src1 = '0;
						src2 = '0;
						dest = '0;
					end
				endcase
			end
			OP_ADDIU:
			begin
				op = ALU_ADD;
				imm = {{16{w.i.imm[15]}}, w.i.imm};
			end
			OP_ANDI: op = ALU_AND;
			OP_ORI:  op = ALU_OR;
			OP_XORI: op = ALU_XOR;
			OP_LUI:  op = ALU_LUI;
			default: op = ALU_NOP;
		endcase
		if (w.i.op != OP_SPECIAL && op != ALU_NOP)
		begin
			// I-type writes rt; LUI reads no register
			src1 = (op == ALU_LUI) ? '0 : w.i.rs;
			dest = w.i.rt;
			use_imm = 1'b1;
			if (w.i.op != OP_ADDIU)
				imm = {16'h0, w.i.imm};
		end
	endfunction

	// newest execute result wins, slot b is younger
	function automatic logic [31:0] fwd(
		input logic [`CORE_REG_BITS-1:0] src,
		input logic [31:0]               rf
	);
		if (ex_valid_b && ex_dest_b != '0 && ex_dest_b == src)
			return res_b;
		if (ex_valid_a && ex_dest_a != '0 && ex_dest_a == src)
			return res_a;
		return rf;
	endfunction

	always_comb
	begin
		decode(head_word_a, op_a, rd_addr1, rd_addr2, dest_a, use_imm_a, imm_a);
		decode(head_word_b, op_b, rd_addr3, rd_addr4, dest_b, use_imm_b, imm_b);
	end

	assign dep_b = (dest_a != '0) && (rd_addr3 == dest_a || rd_addr4 == dest_a);
	assign n_ex = NEED_BITS'(ex_valid_a) + NEED_BITS'(ex_valid_b);

	// results still in execute will claim retire entries first
	assign issue_one = head_valid_a && (room >= NEED_BITS'(1) + n_ex);
	assign issue_two = head_valid_a && head_valid_b && !dep_b
		&& (room >= NEED_BITS'(2) + n_ex);

	assign pop_two = issue_two;
	assign pop_one = issue_one && !issue_two;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ex_valid_a <= 1'b0;
			ex_valid_b <= 1'b0;
		end
		else
		begin
			ex_valid_a <= issue_one;
			ex_valid_b <= issue_two;
		end
	end

	always_ff @(posedge clk)
	begin
		ex_op_a <= op_a;
		ex_dest_a <= dest_a;
		ex_opnd1_a <= fwd(rd_addr1, rd_data1);
		ex_opnd2_a <= use_imm_a ? imm_a : fwd(rd_addr2, rd_data2);
		ex_op_b <= op_b;
		ex_dest_b <= dest_b;
		ex_opnd1_b <= fwd(rd_addr3, rd_data3);
		ex_opnd2_b <= use_imm_b ? imm_b : fwd(rd_addr4, rd_data4);
	end

endmodule

//--- design/pipe_pkg.sv
package pipe_pkg;

	// two execute slots, a and b
	localparam int ISSUE_SLOTS = 2;

	localparam int ALU_OP_BITS = 3;

	// alu operation codes
	localparam logic [ALU_OP_BITS-1:0] ALU_NOP = 3'd0;
	localparam logic [ALU_OP_BITS-1:0] ALU_ADD = 3'd1;
	localparam logic [ALU_OP_BITS-1:0] ALU_SUB = 3'd2;
	localparam logic [ALU_OP_BITS-1:0] ALU_AND = 3'd3;
	localparam logic [ALU_OP_BITS-1:0] ALU_OR  = 3'd4;
	localparam logic [ALU_OP_BITS-1:0] ALU_XOR = 3'd5;
	// signed compare
	localparam logic [ALU_OP_BITS-1:0] ALU_SLT = 3'd6;
	// immediate into upper half
	localparam logic [ALU_OP_BITS-1:0] ALU_LUI = 3'd7;

endpackage

//--- design/reg_file.sv
`include "core_params.svh"

module reg_file (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [`CORE_REG_BITS-1:0] raddr1,
	input  logic [`CORE_REG_BITS-1:0] raddr2,
	input  logic [`CORE_REG_BITS-1:0] raddr3,
	input  logic [`CORE_REG_BITS-1:0] raddr4,
	output logic [31:0]               rdata1,
	output logic [31:0]               rdata2,
	output logic [31:0]               rdata3,
	output logic [31:0]               rdata4,
	input  logic                      we_a,
	input  logic [`CORE_REG_BITS-1:0] waddr_a,
	input  logic [31:0]               wdata_a,
	input  logic                      we_b,
	input  logic [`CORE_REG_BITS-1:0] waddr_b,
	input  logic [31:0]               wdata_b
);
	localparam int NREGS = 1 << `CORE_REG_BITS;

	// no storage behind register 0
	logic [31:0] regs [1:NREGS-1];

	assign rdata1 = (raddr1 == '0) ? 32'd0 : regs[raddr1];
	assign rdata2 = (raddr2 == '0) ? 32'd0 : regs[raddr2];
	assign rdata3 = (raddr3 == '0) ? 32'd0 : regs[raddr3];
	assign rdata4 = (raddr4 == '0) ? 32'd0 : regs[raddr4];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 1; i < NREGS; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (we_a && waddr_a != '0)
				regs[waddr_a] <= wdata_a;
			// port b is younger, so it lands last
			if (we_b && waddr_b != '0)
				regs[waddr_b] <= wdata_b;
		end
	end

endmodule

//--- design/retire_port.sv
`include "core_params.svh"

module retire_port (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      push_a,
	input  logic [`CORE_REG_BITS-1:0] reg_a,
	input  logic [31:0]               data_a,
	input  logic                      push_b,
	input  logic [`CORE_REG_BITS-1:0] reg_b,
	input  logic [31:0]               data_b,
	output logic [3:0]                room,
	input  logic                      retire_credit,
	output logic                      retire_valid,
	output logic [`CORE_REG_BITS-1:0] retire_reg,
	output logic [31:0]               retire_data
);
	localparam int DEPTH = `CORE_RETIRE_DEPTH;
	localparam int PTR = $clog2(DEPTH);
	localparam int CNT = PTR + 1;
	localparam int CRD = $clog2(`CORE_RETIRE_CREDITS + 1);

	logic [`CORE_REG_BITS-1:0] reg_mem [DEPTH];
	logic [31:0]               data_mem [DEPTH];
	logic [PTR-1:0]            wr_ptr;
	logic [PTR-1:0]            wr_ptr_b;
	logic [PTR-1:0]            rd_ptr;
	logic [CNT-1:0]            count;
	logic [CRD-1:0]            credits;
	logic [1:0]                n_push;

	assign n_push = {1'b0, push_a} + {1'b0, push_b};
	// slot b lands right behind slot a
	assign wr_ptr_b = wr_ptr + PTR'(push_a);

	assign room = CNT'(DEPTH) - count;

	// one entry per cycle, one credit each
	assign retire_valid = (count != '0) && (credits != '0);
	assign retire_reg = reg_mem[rd_ptr];
	assign retire_data = data_mem[rd_ptr];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credits <= CRD'(`CORE_RETIRE_CREDITS);
		end
		else
		begin
			wr_ptr <= wr_ptr + PTR'(n_push);
			if (retire_valid)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count + CNT'(n_push) - CNT'(retire_valid);
			credits <= credits + CRD'(retire_credit) - CRD'(retire_valid);
		end
	end

	always_ff @(posedge clk)
	begin
		if (push_a)
		begin
			reg_mem[wr_ptr] <= reg_a;
			data_mem[wr_ptr] <= data_a;
		end
		if (push_b)
		begin
			reg_mem[wr_ptr_b] <= reg_b;
			data_mem[wr_ptr_b] <= data_b;
		end
	end

endmodule

//--- sources.f
+incdir+design
design/isa_pkg.sv
design/pipe_pkg.sv
design/inst_queue.sv
design/issue_ctrl.sv
design/reg_file.sv
design/alu.sv
design/retire_port.sv
design/dual_issue_core.sv
verif/core_sva.sv
verif/tb_core.sv

//--- verif/core_sva.sv
`include "core_params.svh"

module core_sva #(
	parameter int DEPTH = 8
) (
	input logic                                         clk,
	input logic                                         rst_n,
	input logic                                         push_a,
	input logic                                         push_b,
	input logic [3:0]                                   fill,
	input logic                                         give,
	input logic                                         spend,
	input logic [$clog2(`CORE_RETIRE_CREDITS + 1)-1:0] credits,
	input logic [3:0]                                   room
);
	localparam int CRD = $clog2(`CORE_RETIRE_CREDITS + 1);

	// credits granted by the consumer and not yet spent, seen from the pins
	logic [CRD-1:0] granted;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			granted <= CRD'(`CORE_RETIRE_CREDITS);
		else
			granted <= granted + CRD'(give) - CRD'(spend);
	end

	// stored entries plus this cycle's pushes must fit
	a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
		5'(fill) + 5'(push_a) + 5'(push_b) <= 5'(DEPTH))
		else $error("push into a full FIFO, fill %0d", fill);

	a_spend_credit: assert property (@(posedge clk) disable iff (!rst_n)
		spend |-> granted != '0)
		else $error("retire_valid with no output credit");

	a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
		credits <= `CORE_RETIRE_CREDITS)
		else $error("output credits %0d above grant", credits);

	a_room_max: assert property (@(posedge clk) disable iff (!rst_n)
		room <= 4'(`CORE_RETIRE_DEPTH))
		else $error("room %0d above retire depth", room);

endmodule

// input side has no output credits or room
bind inst_queue core_sva #(.DEPTH(`CORE_QUEUE_DEPTH)) u_queue_sva (
	.clk,
	.rst_n,
	.push_a(inst_valid),
	.push_b(1'b0),
	.fill(count),
	.give(1'b0),
	.spend(1'b0),
	.credits('0),
	.room(4'd0)
);

bind retire_port core_sva #(.DEPTH(`CORE_RETIRE_DEPTH)) u_retire_sva (
	.clk,
	.rst_n,
	.push_a,
	.push_b,
	.fill(count),
	.give(retire_credit),
	.spend(retire_valid),
	.credits,
	.room
);

//--- verif/tb_core.sv
`include "core_params.svh"

module tb_core;
	import isa_pkg::*;

	localparam int CLK_PERIOD = 8;
	localparam int QDEPTH = `CORE_QUEUE_DEPTH;
	localparam int RCREDITS = `CORE_RETIRE_CREDITS;
	localparam int HOLD_CYCLES = 30;
	localparam int STALL_CYCLES = 80;
	localparam int RANDOM_WORDS = 200;
	// words sent by the directed tests plus the random stream
	localparam int WORDS_TOTAL = 14 + 8 + 15 + 24 + RANDOM_WORDS;
	// credit gaps can stretch a word to several cycles
	localparam int WATCHDOG_CYCLES = WORDS_TOTAL * 10 + 3 * HOLD_CYCLES + STALL_CYCLES + 200;

	logic        clk;
	logic        rst_n;
	logic        inst_valid;
	logic [31:0] inst_word;
	logic        inst_credit;
	logic        retire_valid;
	logic [4:0]  retire_reg;
	logic [31:0] retire_data;
	logic        retire_credit;

	logic [31:0] send_q [$];
	logic [4:0]  exp_reg_q [$];
	logic [31:0] exp_data_q [$];
	logic [31:0] ref_regs [32];
	int          sender_credits;
	int          owed_credits;
	int          sent_count;
	int          credit_count;
	int          retire_count;
	int          errors;
	int          tests_run;
	int          tests_failed;
	logic        hold_credits;
	logic        credit_gaps;
	integer      seed;

	dual_issue_core i_dut (
		.clk,
		.rst_n,
		.inst_valid,
		.inst_word,
		.inst_credit,
		.retire_valid,
		.retire_reg,
		.retire_data,
		.retire_credit
	);

	initial
		clk = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] r_type(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {OP_SPECIAL, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_type(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	// reference model, one word in program order
	task automatic send_word(input logic [31:0] w);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] zimm;
		logic [31:0] simm;
		logic [31:0] val;
		logic [4:0]  dst;
		a = ref_regs[w[25:21]];
		b = ref_regs[w[20:16]];
		zimm = {16'h0, w[15:0]};
		simm = {{16{w[15]}}, w[15:0]};
		val = 32'd0;
		dst = 5'd0;
		if (w[31:26] == OP_SPECIAL)
		begin
			dst = w[15:11];
			case (w[5:0])
				FN_ADDU: val = a + b;
				FN_SUBU: val = a - b;
				FN_AND:  val = a & b;
				FN_OR:   val = a | b;
				FN_XOR:  val = a ^ b;
				FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default: dst = 5'd0;
			endcase
		end
		else
		begin
			dst = w[20:16];
			case (w[31:26])
				OP_ADDIU: val = a + simm;
				OP_ANDI:  val = a & zimm;
				OP_ORI:   val = a | zimm;
				OP_XORI:  val = a ^ zimm;
				OP_LUI:   val = {w[15:0], 16'h0};
				default:  dst = 5'd0;
			endcase
		end
		if (dst == 5'd0)
			val = 32'd0;
		ref_regs[dst] = val;
		exp_reg_q.push_back(dst);
		exp_data_q.push_back(val);
		send_q.push_back(w);
	endtask

	task automatic check_retire();
		logic [4:0]  want_reg;
		logic [31:0] want_data;
		retire_count++;
		owed_credits++;
		if (exp_reg_q.size() == 0)
		begin
			$display("retire of register %0d with no result outstanding", retire_reg);
			errors++;
		end
		else
		begin
			want_reg = exp_reg_q.pop_front();
			want_data = exp_data_q.pop_front();
			if (retire_reg !== want_reg)
			begin
				$display("MISMATCH retire_reg got %h expected %h", retire_reg, want_reg);
				errors++;
			end
			if (retire_data !== want_data)
			begin
				$display("MISMATCH retire_data got %h expected %h", retire_data, want_data);
				errors++;
			end
		end
	endtask

	// sample outputs, then drive the consumer and the sender
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (retire_valid)
				check_retire();
			retire_credit = 1'b0;
			if (!hold_credits && owed_credits > 0 && (!credit_gaps || ($random(seed) & 1)))
			begin
				retire_credit = 1'b1;
				owed_credits--;
			end
			inst_valid = 1'b0;
			if (send_q.size() > 0 && sender_credits > 0)
			begin
				inst_valid = 1'b1;
				inst_word = send_q.pop_front();
				sender_credits--;
				sent_count++;
			end
			// a credit returned in this cycle is spent from the next one
			if (inst_credit)
			begin
				sender_credits++;
				credit_count++;
			end
		end
	end

	task automatic wait_drain();
		do
			@(posedge clk);
		while (send_q.size() != 0 || exp_reg_q.size() != 0 || owed_credits != 0);
		@(posedge clk);
	endtask

	// let a backlog build in the queue, then drain with credit gaps
	task automatic run_backlogged();
		hold_credits = 1'b1;
		credit_gaps = 1'b1;
		repeat (HOLD_CYCLES) @(posedge clk);
		hold_credits = 1'b0;
		wait_drain();
		credit_gaps = 1'b0;
	endtask

	task automatic finish_test(input string name, input int errs_before);
		tests_run++;
		if (errors == errs_before)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_reset();
		int errs_before;
		errs_before = errors;
		repeat (20)
		begin
			@(negedge clk);
			if (inst_credit !== 1'b0 || retire_valid !== 1'b0)
			begin
				$display("inst_credit or retire_valid high with no word sent");
				errors++;
			end
		end
		finish_test("reset", errs_before);
	endtask

	task automatic test_independent();
		int errs_before;
		errs_before = errors;
		@(posedge clk);
		send_word(i_type(OP_LUI, 5'd1, 5'd0, 16'h8001));
		send_word(i_type(OP_ADDIU, 5'd2, 5'd0, 16'hfffb));
		send_word(i_type(OP_ADDIU, 5'd3, 5'd0, 16'h0003));
		send_word(i_type(OP_ORI, 5'd4, 5'd0, 16'h8421));
		send_word(r_type(FN_SLT, 5'd5, 5'd2, 5'd3));
		send_word(r_type(FN_SLT, 5'd6, 5'd3, 5'd2));
		send_word(r_type(FN_ADDU, 5'd7, 5'd1, 5'd2));
		send_word(r_type(FN_SUBU, 5'd8, 5'd2, 5'd3));
		send_word(r_type(FN_AND, 5'd9, 5'd1, 5'd4));
		send_word(r_type(FN_OR, 5'd10, 5'd4, 5'd2));
		send_word(r_type(FN_XOR, 5'd11, 5'd2, 5'd4));
		send_word(i_type(OP_XORI, 5'd12, 5'd2, 16'hf0f0));
		send_word(i_type(OP_ANDI, 5'd13, 5'd2, 16'h8f0f));
		// both operands negative
		send_word(r_type(FN_SLT, 5'd14, 5'd8, 5'd2));
		run_backlogged();
		finish_test("independent", errs_before);
	endtask

	task automatic test_dependency();
		int errs_before;
		errs_before = errors;
		@(posedge clk);
		send_word(i_type(OP_ADDIU, 5'd1, 5'd0, 16'd1));
		send_word(r_type(FN_ADDU, 5'd1, 5'd1, 5'd1));
		send_word(r_type(FN_ADDU, 5'd1, 5'd1, 5'd1));
		send_word(r_type(FN_ADDU, 5'd2, 5'd1, 5'd1));
		send_word(r_type(FN_SUBU, 5'd3, 5'd2, 5'd1));
		send_word(i_type(OP_ADDIU, 5'd3, 5'd3, 16'hffff));
		send_word(r_type(FN_XOR, 5'd4, 5'd3, 5'd2));
		send_word(r_type(FN_SLT, 5'd5, 5'd4, 5'd3));
		run_backlogged();
		if (credit_count != sent_count)
		begin
			$display("%0d credits returned for %0d words sent", credit_count, sent_count);
			errors++;
		end
		finish_test("dependency", errs_before);
	endtask

	task automatic test_reg_zero();
		int errs_before;
		errs_before = errors;
		@(posedge clk);
		send_word(i_type(OP_ADDIU, 5'd0, 5'd1, 16'h0005));
		send_word(32'h0000_0000);
		send_word(32'h8c22_0004);
		send_word(r_type(6'h18, 5'd6, 5'd1, 5'd2));
		send_word(r_type(FN_ADDU, 5'd0, 5'd1, 5'd2));
		send_word(i_type(OP_ORI, 5'd0, 5'd3, 16'hffff));
		send_word(i_type(OP_LUI, 5'd0, 5'd0, 16'h1234));
		send_word(r_type(FN_SUBU, 5'd0, 5'd2, 5'd1));
		send_word(32'hffff_ffff);
		send_word(32'h0800_0010);
		send_word(32'h1022_fffe);
		send_word(32'h0001_1080);
		// same destination, the younger word must win
		send_word(i_type(OP_ADDIU, 5'd20, 5'd0, 16'h0011));
		send_word(i_type(OP_ADDIU, 5'd20, 5'd0, 16'h0022));
		send_word(r_type(FN_OR, 5'd21, 5'd20, 5'd0));
		run_backlogged();
		finish_test("register zero", errs_before);
	endtask

	task automatic test_backpressure();
		int errs_before;
		int retired_before;
		errs_before = errors;
		@(posedge clk);
		retired_before = retire_count;
		hold_credits = 1'b1;
		for (int k = 0; k < 24; k++)
			send_word(i_type(OP_ADDIU, 5'(16 + k % 8), 5'(16 + k % 8), 16'(k + 1)));
		repeat (STALL_CYCLES) @(posedge clk);
		if (retire_count - retired_before != RCREDITS)
		begin
			$display("%0d results retired with credits withheld, expected %0d",
				retire_count - retired_before, RCREDITS);
			errors++;
		end
		if (sender_credits != 0)
		begin
			$display("sender still holds %0d credits behind a stalled core", sender_credits);
			errors++;
		end
		hold_credits = 1'b0;
		wait_drain();
		finish_test("back-pressure", errs_before);
	endtask

	task automatic test_random();
		int          errs_before;
		logic [31:0] r;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [4:0]  rd;
		errs_before = errors;
		@(posedge clk);
		credit_gaps = 1'b1;
		for (int k = 0; k < RANDOM_WORDS; k++)
		begin
			r = $random(seed);
			// sixteen registers, so dependencies are common
			rs = {1'b0, r[7:4]};
			rt = {1'b0, r[11:8]};
			rd = {1'b0, r[15:12]};
			case (int'(r[3:0]) % 11)
				0:       send_word(r_type(FN_ADDU, rd, rs, rt));
				1:       send_word(r_type(FN_SUBU, rd, rs, rt));
				2:       send_word(r_type(FN_AND, rd, rs, rt));
				3:       send_word(r_type(FN_OR, rd, rs, rt));
				4:       send_word(r_type(FN_XOR, rd, rs, rt));
				5:       send_word(r_type(FN_SLT, rd, rs, rt));
				6:       send_word(i_type(OP_ADDIU, rt, rs, r[31:16]));
				7:       send_word(i_type(OP_ANDI, rt, rs, r[31:16]));
				8:       send_word(i_type(OP_ORI, rt, rs, r[31:16]));
				9:       send_word(i_type(OP_XORI, rt, rs, r[31:16]));
				default: send_word(i_type(OP_LUI, rt, rs, r[31:16]));
			endcase
		end
		wait_drain();
		credit_gaps = 1'b0;
		finish_test("random", errs_before);
	endtask

	initial
	begin
		rst_n = 1'b0;
		inst_valid = 1'b0;
		inst_word = 32'd0;
		retire_credit = 1'b0;
		hold_credits = 1'b0;
		credit_gaps = 1'b0;
		seed = 32'h74d25ed0;
		sender_credits = QDEPTH;
		owed_credits = 0;
		sent_count = 0;
		credit_count = 0;
		retire_count = 0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		for (int i = 0; i < 32; i++)
			ref_regs[i] = 32'd0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		test_reset();
		test_independent();
		test_dependency();
		test_reg_zero();
		test_backpressure();
		test_random();
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog expired after %0d cycles with %0d results outstanding",
			WATCHDOG_CYCLES, exp_reg_q.size());
		$display("TESTS FAILED");
		$finish;
	end

endmodule
